// File: mac_gmii.f
+incdir+include
design/mac_pkg.sv
design/mac_crc32.sv
design/mac_rx_path.sv
design/mac_tx_path.sv
design/mac_gmii.sv
sim/tb_mac_gmii.sv

// File: Makefile
# Verilator build and run for the byte-wide MAC framer
# override any variable on the command line, e.g. make OBJ_DIR=build

VERILATOR  ?= verilator
TOP        ?= tb_mac_gmii
FILELIST   ?= mac_gmii.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the testbench ends every failing run with $fatal, so the exit status carries the result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_mac_gmii.sv
// testbench for mac_gmii, one GMII byte per cycle in both PHY directions
// FCS comes from a bit-serial CRC model; loopback ties gmii_tx_o back to gmii_rx_i
`include "mac_defs.svh"

module tb_mac_gmii;
    timeunit 1ns;
    timeprecision 1ps;
    import mac_pkg::*;

    typedef logic [7:0] byte_q_t [$];

    typedef struct packed {
        logic [31:0] at;                        // cycle the byte is due
        logic [7:0]  data;
    } tx_beat_t;

    typedef struct packed {
        logic [31:0] at;
        logic        sof;
        logic        eof;
        logic [7:0]  data;
    } rx_beat_t;

    typedef struct packed {
        logic [31:0] at;
        logic [3:0]  nib;
    } stat_beat_t;

    logic        mac_rx_clk;
    logic        rst_n_i;
    gmii_rx_t    gmii_rx_i;
    gmii_rx_t    rx_drv;                        // bytes driven by the tasks
    gmii_rx_t    loop_rx;                       // gmii_tx_o turned around
    gmii_tx_t    gmii_tx_o;
    mac_stream_t tx_stream_i;
    mac_stream_t rx_stream_o;
    eth_status_t eth_status_o;
    logic        loopback;
    logic [3:0]  status_nib;                    // carried on every idle byte
    logic [31:0] cyc = '0;

    tx_beat_t    exp_tx[$];
    rx_beat_t    exp_rx[$];
    stat_beat_t  exp_stat[$];

    assign loop_rx   = {gmii_tx_o.en, 1'b0, gmii_tx_o.data};   // dv from en, err low
    assign gmii_rx_i = loopback ? loop_rx : rx_drv;

    mac_gmii dut0 (
        .mac_rx_clk   (mac_rx_clk),
        .rst_n_i      (rst_n_i),
        .gmii_rx_i    (gmii_rx_i),
        .gmii_tx_o    (gmii_tx_o),
        .tx_stream_i  (tx_stream_i),
        .rx_stream_o  (rx_stream_o),
        .eth_status_o (eth_status_o)
    );

    initial begin
        mac_rx_clk = 1'b0;
        forever #5 mac_rx_clk = ~mac_rx_clk;
    end

    always @(posedge mac_rx_clk) cyc <= cyc + 1;   // sampled at negedge, settled by then

    // ------------------------------------------------------------
    // reference model and expected queues
    // ------------------------------------------------------------
    function automatic logic [31:0] ref_fcs(input byte_q_t bytes);
        logic [31:0] crc;
        crc = `MAC_CRC_INIT;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                if (crc[0] ^ bytes[i][b])           // LSB of each byte goes first
                    crc = (crc >> 1) ^ `MAC_CRC_POLY;
                else
                    crc = crc >> 1;
            end
        end
        return ~crc;
    endfunction

    function automatic byte_q_t build_frame(input byte_q_t payload);
        byte_q_t     frame;
        logic [31:0] fcs;
        fcs = ref_fcs(payload);
        repeat (`MAC_PREAMBLE_LEN) frame.push_back(`MAC_PREAMBLE_BYTE);
        frame.push_back(`MAC_SFD_BYTE);
        foreach (payload[k]) frame.push_back(payload[k]);
        for (int i = 0; i < `MAC_FCS_LEN; i++) frame.push_back(fcs[8*i +: 8]);   // low first
        return frame;
    endfunction

    function automatic void expect_tx_frame(input byte_q_t payload, input logic [31:0] t);
        byte_q_t frame;
        frame = build_frame(payload);
        foreach (frame[j]) begin
            tx_beat_t beat;
            beat.at   = (j < `MAC_PREAMBLE_LEN + 1) ? t + 1 + j
                                                    : t + `MAC_TX_LATENCY + j - 8;
            beat.data = frame[j];
            exp_tx.push_back(beat);
        end
    endfunction

    // t0 is the edge where frame byte 0 is sampled
    function automatic void expect_rx_frame(input byte_q_t frame, input logic [31:0] t0,
                                            input logic good);
        rx_beat_t beat;
        for (int j = `MAC_PREAMBLE_LEN + 1; j < frame.size(); j++) begin
            beat.at   = t0 + j + `MAC_RX_LATENCY;
            beat.sof  = (j == `MAC_PREAMBLE_LEN + 1);
            beat.eof  = good && (j == frame.size() - 1);   // eof only on a good FCS
            beat.data = frame[j];
            exp_rx.push_back(beat);
        end
    endfunction

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at cycle %0d", cyc);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            stop_fail($sformatf("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // ------------------------------------------------------------
    // stimulus tasks, all inputs change on the rising edge
    // ------------------------------------------------------------
    task automatic rand_payload(output byte_q_t p);
        int n;
        p = {};
        n = 1 + ($urandom % 64);
        repeat (n) p.push_back(8'($urandom));
    endtask

    // one frame on tx_stream_i, then the minimum 16 cycle gap
    task automatic send_tx(input byte_q_t payload, input logic turn_around);
        logic [31:0] t;
        for (int k = 0; k < payload.size(); k++) begin
            @(posedge mac_rx_clk);
            tx_stream_i <= '{sof: (k == 0), eof: (k == payload.size() - 1), valid: 1'b1,
                             data: payload[k]};
            if (k == 0) begin
                t = cyc + 2;                        // edge where sof is sampled
                expect_tx_frame(payload, t);
                if (turn_around)
                    expect_rx_frame(build_frame(payload), t + 2, 1'b1);
            end
        end
        repeat (15) begin
            @(posedge mac_rx_clk);
            tx_stream_i <= '0;
        end
    endtask

    task automatic rx_idle(input int n);
        repeat (n) begin
            @(posedge mac_rx_clk);
            rx_drv <= '{dv: 1'b0, err: 1'b0, data: {4'h0, status_nib}};
        end
    endtask

    task automatic send_rx(input byte_q_t frame, input logic good);
        for (int j = 0; j < frame.size(); j++) begin
            @(posedge mac_rx_clk);
            rx_drv <= '{dv: 1'b1, err: 1'b0, data: frame[j]};
            if (j == 0)
                expect_rx_frame(frame, cyc + 2, good);
        end
        rx_idle(12);
    endtask

    task automatic drive_status(input logic [3:0] nib);
        stat_beat_t beat;
        @(posedge mac_rx_clk);
        status_nib = nib;
        rx_drv    <= '{dv: 1'b0, err: 1'b0, data: {4'h0, nib}};
        beat.at    = cyc + 2 + `MAC_RX_LATENCY;
        beat.nib   = nib;
        exp_stat.push_back(beat);
    endtask

    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (exp_tx.size() != 0 || exp_rx.size() != 0 || exp_stat.size() != 0) begin
            if (n == max_cycles)
                stop_fail("timed out waiting for the expected DUT output");
            @(posedge mac_rx_clk);
            n++;
        end
    endtask

    // ------------------------------------------------------------
    // checking process, outputs are stable at the falling edge
    // ------------------------------------------------------------
    always @(negedge mac_rx_clk) begin : compare_outputs
        tx_beat_t   txb;
        rx_beat_t   rxb;
        stat_beat_t stb;
        if (rst_n_i) begin
            if (gmii_tx_o.en) begin
                if (exp_tx.size() == 0) begin
                    stop_fail("transmit enable high with no byte expected");
                end else begin
                    txb = exp_tx.pop_front();
                    if (txb.at != cyc)
                        stop_fail($sformatf("transmit byte at cycle %0d, due at %0d",
                                            cyc, txb.at));
                    check_eq("gmii_tx_o.data", gmii_tx_o.data, txb.data);
                end
            end else begin
                check_eq("gmii_tx_o.data", gmii_tx_o.data, 0);   // zero while idle
                if (exp_tx.size() != 0 && exp_tx[0].at <= cyc)
                    stop_fail("transmit enable low where a byte was due");
            end
            if (rx_stream_o.valid) begin
                if (exp_rx.size() == 0) begin
                    stop_fail("receive valid high with no byte expected");
                end else begin
                    rxb = exp_rx.pop_front();
                    if (rxb.at != cyc)
                        stop_fail($sformatf("receive byte at cycle %0d, due at %0d",
                                            cyc, rxb.at));
                    check_eq("rx_stream_o.sof", rx_stream_o.sof, rxb.sof);
                    check_eq("rx_stream_o.eof", rx_stream_o.eof, rxb.eof);
                    check_eq("rx_stream_o.data", rx_stream_o.data, rxb.data);
                end
            end else begin
                check_eq("rx_stream_o.sof", rx_stream_o.sof, 0);
                check_eq("rx_stream_o.eof", rx_stream_o.eof, 0);
                if (exp_rx.size() != 0 && exp_rx[0].at <= cyc)
                    stop_fail("receive valid low where a byte was due");
            end
            if (exp_stat.size() != 0 && exp_stat[0].at == cyc) begin
                stb = exp_stat.pop_front();
                check_eq("eth_status_o", {28'h0, eth_status_o}, {28'h0, stb.nib});
            end
        end
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin : run_tests
        byte_q_t payload;
        byte_q_t frame;
        int      idx;
        rst_n_i     = 1'b0;
        tx_stream_i = '0;
        rx_drv      = '0;
        loopback    = 1'b0;
        status_nib  = '0;
        void'($urandom(38157));
        repeat (3) @(posedge mac_rx_clk);
        rst_n_i <= 1'b1;
        @(negedge mac_rx_clk);
        check_eq("gmii_tx_o.en", gmii_tx_o.en, 0);
        check_eq("rx_stream_o.sof", rx_stream_o.sof, 0);
        check_eq("rx_stream_o.eof", rx_stream_o.eof, 0);
        check_eq("rx_stream_o.valid", rx_stream_o.valid, 0);
        check_eq("eth_status_o", {28'h0, eth_status_o}, 0);

        for (int f = 0; f < 3; f++) begin           // transmit framing
            rand_payload(payload);
            send_tx(payload, 1'b0);
        end
        wait_drained(200);

        rand_payload(payload);                      // good receive frame
        send_rx(build_frame(payload), 1'b1);
        wait_drained(200);

        frame = build_frame(payload);               // same frame, one payload bit flipped
        idx   = 8 + ($urandom % payload.size());
        frame[idx] = frame[idx] ^ (8'h01 << ($urandom % 8));
        send_rx(frame, 1'b0);
        wait_drained(200);

        for (int s = 0; s < 6; s++) begin           // in-band status between frames
            drive_status(4'($urandom));
            rx_idle(2);
        end
        wait_drained(20);

        @(posedge mac_rx_clk);
        loopback <= 1'b1;
        for (int f = 0; f < 4; f++) begin           // back to back at the minimum gap
            rand_payload(payload);
            send_tx(payload, 1'b1);
        end
        wait_drained(300);

        if (exp_tx.size() == 0 && exp_rx.size() == 0 && exp_stat.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_fail("expected DUT output left over at the end of the run");
        end
    end

endmodule

// File: design/mac_gmii.sv
// byte-wide Ethernet MAC framer, 1 Gb/s GMII-style bytes on one clock
// neither stream has back-pressure; receive and transmit run independently

module mac_gmii (
    input  logic                 mac_rx_clk,
    input  logic                 rst_n_i,
    // PHY side
    input  mac_pkg::gmii_rx_t    gmii_rx_i,
    output mac_pkg::gmii_tx_t    gmii_tx_o,
    // user side
    input  mac_pkg::mac_stream_t tx_stream_i,
    output mac_pkg::mac_stream_t rx_stream_o,
    output mac_pkg::eth_status_t eth_status_o
);

    // ------------------------------------------------------------
    // receive, preamble strip and CRC check
    // ------------------------------------------------------------
    mac_rx_path rx0 (
        .mac_rx_clk   (mac_rx_clk),
        .rst_n_i      (rst_n_i),
        .gmii_rx_i    (gmii_rx_i),
        .rx_stream_o  (rx_stream_o),
        .eth_status_o (eth_status_o)
    );

    // ------------------------------------------------------------
    // transmit, preamble insert and FCS append
    // ------------------------------------------------------------
    mac_tx_path tx0 (
        .mac_rx_clk  (mac_rx_clk),
        .rst_n_i     (rst_n_i),
        .tx_stream_i (tx_stream_i),
        .gmii_tx_o   (gmii_tx_o)
    );

endmodule

// File: design/mac_tx_path.sv
// transmit framer, prepends preamble and SFD and appends the FCS
// user must keep valid high from sof to eof and leave 16 idle cycles between frames
`include "mac_defs.svh"

module mac_tx_path (
    input  logic                 mac_rx_clk,
    input  logic                 rst_n_i,
    input  mac_pkg::mac_stream_t tx_stream_i,
    output mac_pkg::gmii_tx_t    gmii_tx_o
);
    import mac_pkg::*;

    localparam logic [2:0] PRE_LAST = 3'(`MAC_PREAMBLE_LEN - 1);
    localparam logic [2:0] FCS_LAST = 3'(`MAC_FCS_LEN - 1);
    localparam int         DLY_LAST = `MAC_TX_LATENCY - 1;   // tap feeding the output

    tx_state_e                  state;
    logic [2:0]                 cnt;                         // preamble or FCS byte
    logic [`MAC_DATA_W-1:0]     dly_data [`MAC_TX_LATENCY];
    logic [`MAC_TX_LATENCY-1:0] dly_last;                    // eof marker, same taps
    logic                       last_in;
    logic [31:0]                crc;
    logic [31:0]                fcs_q;

    assign last_in = tx_stream_i.valid && tx_stream_i.eof;

    // ------------------------------------------------------------
    // payload delay line, covers preamble and SFD time
    // ------------------------------------------------------------
    always_ff @(posedge mac_rx_clk) begin
        dly_data[0] <= tx_stream_i.valid ? tx_stream_i.data : '0;
        for (int i = 1; i < `MAC_TX_LATENCY; i++) begin
            dly_data[i] <= dly_data[i-1];
        end
    end

    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dly_last <= '0;
        end else begin
            dly_last <= {dly_last[DLY_LAST-1:0], last_in};
        end
    end

    // ------------------------------------------------------------
    // FCS over the undelayed payload
    // ------------------------------------------------------------
    mac_crc32 crc0 (
        .mac_rx_clk (mac_rx_clk),
        .rst_n_i    (rst_n_i),
        .clear_i    (!tx_stream_i.valid),    // idle between frames
        .en_i       (tx_stream_i.valid),
        .data_i     (tx_stream_i.data),
        .crc_o      (crc)
    );

    // capture one cycle after eof, crc then holds the last byte too
    always_ff @(posedge mac_rx_clk) begin
        if (dly_last[0])
            fcs_q <= ~crc;
        else if (state == TX_FCS)
            fcs_q <= {8'h00, fcs_q[31:8]};    // low byte goes out first
    end

    // ------------------------------------------------------------
    // sequencer, state names the byte loaded into gmii_tx_o next
    // ------------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= TX_IDLE;
            cnt       <= '0;
            gmii_tx_o <= '0;
        end else begin
            gmii_tx_o <= '0;                 // en low and data zero unless overridden
            case (state)
                TX_IDLE: begin
                    if (tx_stream_i.valid && tx_stream_i.sof) begin
                        state <= TX_PREAMBLE;
                        cnt   <= '0;
                    end
                end
                TX_PREAMBLE: begin
                    gmii_tx_o <= '{en: 1'b1, data: `MAC_PREAMBLE_BYTE};
                    cnt       <= cnt + 3'd1;
                    if (cnt == PRE_LAST)
                        state <= TX_SFD;
                end
                TX_SFD: begin
                    gmii_tx_o <= '{en: 1'b1, data: `MAC_SFD_BYTE};
                    state     <= TX_DATA;
                end
                TX_DATA: begin
                    gmii_tx_o <= '{en: 1'b1, data: dly_data[DLY_LAST]};
                    if (dly_last[DLY_LAST]) begin    // last payload byte leaving
                        state <= TX_FCS;
                        cnt   <= '0;
                    end
                end
                TX_FCS: begin
                    gmii_tx_o <= '{en: 1'b1, data: fcs_q[7:0]};
                    cnt       <= cnt + 3'd1;
                    if (cnt == FCS_LAST)
                        state <= TX_IDLE;        // en drops on the next edge
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // the gap rule keeps frames from overlapping in the sequencer
    a_sof_idle: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        tx_stream_i.valid && tx_stream_i.sof |-> state == TX_IDLE);

endmodule

// File: design/mac_rx_path.sv
// receive framer, strips preamble and SFD by count and does not check the SFD value
// eof only on a CRC residue match; rx_err bytes are passed on, not flagged
`include "mac_defs.svh"

module mac_rx_path (
    input  logic                 mac_rx_clk,
    input  logic                 rst_n_i,
    input  mac_pkg::gmii_rx_t    gmii_rx_i,
    output mac_pkg::mac_stream_t rx_stream_o,
    output mac_pkg::eth_status_t eth_status_o
);
    import mac_pkg::*;

    localparam logic [3:0] SFD_IDX   = 4'(`MAC_PREAMBLE_LEN);      // byte 7
    localparam logic [3:0] FIRST_IDX = 4'(`MAC_PREAMBLE_LEN + 1);  // byte 8
    localparam logic [3:0] BODY_IDX  = FIRST_IDX + 4'd1;           // saturates here

    gmii_rx_t               rx_q;          // registered PHY byte
    rx_state_e              state;
    logic [3:0]             cnt;           // index of the byte in rx_q
    logic                   payload;
    logic                   first;

    logic                   s1_valid, s1_sof, s1_idle;
    logic [`MAC_DATA_W-1:0] s1_data;
    logic                   s2_valid, s2_sof, s2_idle;
    logic [`MAC_DATA_W-1:0] s2_data;

    logic [31:0]            crc;
    logic [31:0]            crc_rev;
    logic                   crc_match;
    logic                   eof_seen;      // rest of frame is dropped after eof
    logic                   out_sof, out_eof, out_valid;
    logic [`MAC_DATA_W-1:0] out_data;

    // ------------------------------------------------------------
    // input register and byte framer
    // ------------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_q <= '0;
        end else begin
            rx_q <= gmii_rx_i;
        end
    end

    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state <= RX_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (rx_q.dv) begin                 // byte 0 seen
                        state <= RX_PREAMBLE;
                        cnt   <= 4'd1;
                    end
                end
                RX_PREAMBLE: begin
                    if (!rx_q.dv) begin
                        state <= RX_IDLE;              // runt, drop it
                    end else begin
                        cnt <= cnt + 4'd1;
                        if (cnt == SFD_IDX)
                            state <= RX_FRAME;
                    end
                end
                RX_FRAME: begin
                    if (!rx_q.dv)
                        state <= RX_IDLE;
                    else if (cnt != BODY_IDX)
                        cnt <= cnt + 4'd1;
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assign payload = (state == RX_FRAME) && rx_q.dv;
    assign first   = payload && (cnt == FIRST_IDX);

    // ------------------------------------------------------------
    // two delay stages, CRC folds between them
    // ------------------------------------------------------------
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
            s1_sof   <= 1'b0;
            s1_idle  <= 1'b0;
            s2_valid <= 1'b0;
            s2_sof   <= 1'b0;
            s2_idle  <= 1'b0;
        end else begin
            s1_valid <= payload;
            s1_sof   <= first;
            s1_idle  <= !rx_q.dv && !rx_q.err;         // status byte between frames
            s2_valid <= s1_valid;
            s2_sof   <= s1_sof;
            s2_idle  <= s1_idle;
        end
    end

    always_ff @(posedge mac_rx_clk) begin
        s1_data <= rx_q.data;
        s2_data <= s1_data;                            // lines up with crc
    end

    // crc is held at init outside the payload
    mac_crc32 crc0 (
        .mac_rx_clk (mac_rx_clk),
        .rst_n_i    (rst_n_i),
        .clear_i    (!s1_valid),
        .en_i       (s1_valid),
        .data_i     (s1_data),
        .crc_o      (crc)
    );

    assign crc_rev   = {<<{crc}};                      // residue is given MSB first
    assign crc_match = (crc_rev == `MAC_CRC_RESIDUE);

    // output stage
    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_sof      <= 1'b0;
            out_eof      <= 1'b0;
            out_valid    <= 1'b0;
            eof_seen     <= 1'b0;
            eth_status_o <= '0;                        // link down, 10M, half
        end else begin
            out_sof   <= s2_sof;
            out_valid <= s2_valid && !eof_seen;
            out_eof   <= s2_valid && !eof_seen && crc_match;
            eof_seen  <= s2_valid && (eof_seen || crc_match);
            if (s2_idle)
                eth_status_o <= eth_status_t'(s2_data[3:0]);
        end
    end

    always_ff @(posedge mac_rx_clk) begin
        out_data <= s2_data;
    end

    assign rx_stream_o = '{sof: out_sof, eof: out_eof, valid: out_valid, data: out_data};

    // eof belongs to a valid beat whose byte had dv on the PHY side
    // the sampled eof was registered one edge before this check
    a_eof_valid: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        rx_stream_o.eof |-> rx_stream_o.valid && $past(gmii_rx_i.dv, `MAC_RX_LATENCY + 1));

    a_sof_new_frame: assert property (@(posedge mac_rx_clk) disable iff (!rst_n_i)
        rx_stream_o.sof |-> !$past(rx_stream_o.valid));

endmodule

// File: design/mac_crc32.sv
// raw reflected CRC-32 register, one byte per enabled cycle, LSB first
// crc_o is not complemented; clear_i wins over en_i
`include "mac_defs.svh"

module mac_crc32 (
    input  logic                   mac_rx_clk,
    input  logic                   rst_n_i,
    input  logic                   clear_i,   // load init value
    input  logic                   en_i,      // fold data_i this cycle
    input  logic [`MAC_DATA_W-1:0] data_i,
    output logic [31:0]            crc_o
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // ------------------------------------------------------------
    // byte fold, eight serial steps unrolled
    // ------------------------------------------------------------
    function automatic logic [31:0] crc_fold(
        input logic [31:0]            crc,
        input logic [`MAC_DATA_W-1:0] data
    );
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int i = 0; i < `MAC_DATA_W; i++) begin
            fb = c[0] ^ data[i];                       // feedback bit
            c  = (c >> 1) ^ (fb ? `MAC_CRC_POLY : 32'h0);
        end
        return c;
    endfunction

    assign crc_next = crc_fold(crc_q, data_i);

    always_ff @(posedge mac_rx_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            crc_q <= `MAC_CRC_INIT;
        end else if (clear_i) begin
            crc_q <= `MAC_CRC_INIT;                    // restart for next frame
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    assign crc_o = crc_q;

endmodule

// File: design/mac_pkg.sv
// shared PHY-side and user-side types for the byte-wide MAC
// struct field order fixes the bit layout seen on the ports
`include "mac_defs.svh"

package mac_pkg;

    // PHY receive byte, GMII style
    typedef struct packed {
        logic                   dv;     // data valid
        logic                   err;    // receive error
        logic [`MAC_DATA_W-1:0] data;
    } gmii_rx_t;

    // PHY transmit byte
    typedef struct packed {
        logic                   en;
        logic [`MAC_DATA_W-1:0] data;
    } gmii_tx_t;

    // user stream beat, no back-pressure
    typedef struct packed {
        logic                   sof;
        logic                   eof;    // rx side only on a good CRC
        logic                   valid;
        logic [`MAC_DATA_W-1:0] data;
    } mac_stream_t;

    typedef enum logic [1:0] {
        SPEED_10M  = 2'b00,
        SPEED_100M = 2'b01,
        SPEED_1G   = 2'b10,
        SPEED_RSVD = 2'b11
    } eth_speed_e;

    // in-band status nibble, bit 0 is link
    typedef struct packed {
        logic       duplex;             // 1 = full
        eth_speed_e speed;
        logic       link;               // 1 = up
    } eth_status_t;

    typedef enum logic [2:0] {TX_IDLE, TX_PREAMBLE, TX_SFD, TX_DATA, TX_FCS} tx_state_e;

    typedef enum logic [1:0] {RX_IDLE, RX_PREAMBLE, RX_FRAME} rx_state_e;

endpackage

// File: include/mac_defs.svh
// fixed IEEE 802.3 framing and CRC constants for the byte-wide MAC
// latencies are in mac_rx_clk cycles and must match the RTL pipelines
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// ------------------------------------------------------------
// framing
// ------------------------------------------------------------
`define MAC_DATA_W          8               // one GMII byte per cycle
`define MAC_PREAMBLE_LEN    7               // preamble bytes ahead of the SFD
`define MAC_PREAMBLE_BYTE   8'h55
`define MAC_SFD_BYTE        8'hD5
`define MAC_FCS_LEN         4               // CRC-32 trailer bytes

// ------------------------------------------------------------
// CRC-32, reflected form
// ------------------------------------------------------------
`define MAC_CRC_POLY        32'hEDB8_8320
`define MAC_CRC_INIT        32'hFFFF_FFFF
`define MAC_CRC_RESIDUE     32'hC704_DD7B   // normal bit order, good frame incl. FCS

// pipeline latencies
`define MAC_RX_LATENCY      3               // gmii_rx_i sample to rx_stream_o
`define MAC_TX_LATENCY      9               // payload byte in to gmii_tx_o

`endif
